// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module datapathTb -f build.f
	@out=$$(./obj_dir/VdatapathTb); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+include
src/cpuPkg.sv
src/registerFile.sv
src/busEncoder.sv
src/aluUnit.sv
src/memDataReg.sv
src/cpuDatapath.sv
verification/datapathTb.sv

// File: src/aluUnit.sv
module aluUnit (
        input  cpuPkg::aluOp                   operation,
        input  logic [cpuPkg::dataWidth-1:0]   yValue,
        input  logic [cpuPkg::dataWidth-1:0]   busData,
        output logic [2*cpuPkg::dataWidth-1:0] result
);

        logic [cpuPkg::dataWidth-1:0]   low;
        logic [2*cpuPkg::dataWidth-1:0] product;
        logic [4:0]                     shiftAmount;

        assign shiftAmount = busData[4:0];  // only the low five bits count

        // signed 32x32 product
        assign product = $signed(yValue) * $signed(busData);

        always_comb begin
                low = '0;
                case (operation)
                        cpuPkg::opAdd: begin
                                low = yValue + busData;
                        end
                        cpuPkg::opSub: begin
                                low = yValue - busData;
                        end
                        cpuPkg::opAnd: begin
                                low = yValue & busData;
                        end
                        cpuPkg::opOr: begin
                                low = yValue | busData;
                        end
                        cpuPkg::opShl: begin
                                low = yValue << shiftAmount;
                        end
                        cpuPkg::opShr: begin
                                low = yValue >> shiftAmount;  // zero fill
                        end
                        cpuPkg::opNeg: begin
                                low = -busData;
                        end
                        cpuPkg::opNot: begin
                                low = ~busData;
                        end
                        cpuPkg::opIncPc: begin
                                low = busData + 1'b1;
                        end
                        cpuPkg::opPass: begin
                                low = busData;
                        end
                        cpuPkg::opMul: begin
                                low = product[cpuPkg::dataWidth-1:0];
                        end
                        default: begin
                                low = '0;
                                // x is tolerated before the sequencer drives aluCode
                                assert ($isunknown(operation))
                                        else $error("aluUnit: undefined opcode %0d",
                                                    operation);
                        end
                endcase
        end

        // only multiply fills the high half
        always_comb begin
                if (operation == cpuPkg::opMul)
                        result = product;
                else
                        result = {{cpuPkg::dataWidth{1'b0}}, low};
        end

endmodule

// File: src/busEncoder.sv
module busEncoder (
        input  logic                         pcOut,
        input  logic                         zHighOut,
        input  logic                         zLowOut,
        input  logic                         mdrOut,
        input  logic                         irOut,
        input  logic [cpuPkg::regCount-1:0]  regOut,
        input  logic [cpuPkg::dataWidth-1:0] regValue,
        input  logic [cpuPkg::dataWidth-1:0] pcValue,
        input  logic [cpuPkg::dataWidth-1:0] zHighValue,
        input  logic [cpuPkg::dataWidth-1:0] zLowValue,
        input  logic [cpuPkg::dataWidth-1:0] mdrValue,
        input  logic [cpuPkg::dataWidth-1:0] irValue,
        output logic [cpuPkg::dataWidth-1:0] busData
);

        cpuPkg::busSource source;
        logic [5:0]       enables;

        assign enables = {pcOut, zHighOut, zLowOut, mdrOut, irOut, |regOut};

        // strobes to source code
        always_comb begin
                if (|regOut)
                        source = cpuPkg::srcReg;
                else if (pcOut)
                        source = cpuPkg::srcPc;
                else if (zHighOut)
                        source = cpuPkg::srcZHigh;
                else if (zLowOut)
                        source = cpuPkg::srcZLow;
                else if (mdrOut)
                        source = cpuPkg::srcMdr;
                else if (irOut)
                        source = cpuPkg::srcIr;
                else
                        source = cpuPkg::srcNone;

                // the shared bus has exactly one driver, never two
                assert ($onehot0(enables) || $isunknown(enables))
                        else $error("busEncoder: several out-enables high (%b)", enables);
        end

        always_comb begin
                case (source)
                        cpuPkg::srcReg:   busData = regValue;
                        cpuPkg::srcPc:    busData = pcValue;
                        cpuPkg::srcZHigh: busData = zHighValue;
                        cpuPkg::srcZLow:  busData = zLowValue;
                        cpuPkg::srcMdr:   busData = mdrValue;
                        cpuPkg::srcIr:    busData = irValue;
                        default:          busData = '0;  // idle bus reads zero
                endcase
        end

endmodule

// File: src/cpuDatapath.sv
module cpuDatapath (
        input  logic                         Clock,
        input  logic                         rstN,
        input  logic                         pcOut,
        input  logic                         zHighOut,
        input  logic                         zLowOut,
        input  logic                         mdrOut,
        input  logic                         irOut,
        input  logic [cpuPkg::regCount-1:0]  regOut,
        input  logic                         pcIn,
        input  logic                         irIn,
        input  logic                         yIn,
        input  logic                         marIn,
        input  logic                         zIn,
        input  logic                         mdrIn,
        input  logic [cpuPkg::regCount-1:0]  regIn,
        input  logic                         incPc,
        input  cpuPkg::aluOp                 aluCode,
        input  logic                         read,
        input  logic [cpuPkg::dataWidth-1:0] mdataIn,
        output logic [cpuPkg::dataWidth-1:0] busData,
        output logic [cpuPkg::dataWidth-1:0] mdrValue,
        output logic [cpuPkg::dataWidth-1:0] marValue,
        output logic [cpuPkg::dataWidth-1:0] irValue
);

        logic [cpuPkg::dataWidth-1:0]   pcValue;
        logic [cpuPkg::dataWidth-1:0]   yValue;
        logic [cpuPkg::dataWidth-1:0]   zHighValue;
        logic [cpuPkg::dataWidth-1:0]   zLowValue;
        logic [cpuPkg::dataWidth-1:0]   regValue;
        logic [2*cpuPkg::dataWidth-1:0] aluResult;
        cpuPkg::aluOp                   operation;

        // fetch step overrides whatever aluCode says
        assign operation = incPc ? cpuPkg::opIncPc : aluCode;

        // PC, IR, Y and MAR all take the bus on their strobe
        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        pcValue  <= '0;
                        irValue  <= '0;
                        yValue   <= '0;
                        marValue <= '0;
                end else begin
                        if (pcIn)
                                pcValue <= busData;
                        if (irIn)
                                irValue <= busData;
                        if (yIn)
                                yValue <= busData;
                        if (marIn)
                                marValue <= busData;
                end
        end

        // Z captures both halves of the ALU result at once
        always_ff @(posedge Clock) begin
                if (!rstN)
                        {zHighValue, zLowValue} <= '0;
                else if (zIn)
                        {zHighValue, zLowValue} <= aluResult;
        end

        registerFile i_registerFile (
                .Clock    (Clock),
                .rstN     (rstN),
                .busData  (busData),
                .regIn    (regIn),
                .regOut   (regOut),
                .regValue (regValue)
        );

        busEncoder i_busEncoder (
                .pcOut      (pcOut),
                .zHighOut   (zHighOut),
                .zLowOut    (zLowOut),
                .mdrOut     (mdrOut),
                .irOut      (irOut),
                .regOut     (regOut),
                .regValue   (regValue),
                .pcValue    (pcValue),
                .zHighValue (zHighValue),
                .zLowValue  (zLowValue),
                .mdrValue   (mdrValue),
                .irValue    (irValue),
                .busData    (busData)
        );

        aluUnit i_aluUnit (
                .operation (operation),
                .yValue    (yValue),
                .busData   (busData),
                .result    (aluResult)
        );

        memDataReg i_memDataReg (
                .Clock    (Clock),
                .rstN     (rstN),
                .busData  (busData),
                .mdataIn  (mdataIn),
                .read     (read),
                .mdrIn    (mdrIn),
                .mdrValue (mdrValue)
        );

        // in the fetch step PC out with incPc and zIn leaves PC + 1 in Z low
        assert property (@(posedge Clock) disable iff (!rstN)
                        incPc && zIn && pcOut |=> zLowValue == $past(pcValue) + 1)
                else $error("cpuDatapath: PC increment not captured in Z");

endmodule

// File: src/cpuPkg.sv
package cpuPkg;

        localparam int dataWidth = 32;  // word and bus width
        localparam int regCount  = 16;  // general registers R0..R15

        // which unit currently drives the shared bus
        typedef enum logic [2:0] {
                srcNone  = 3'd0,  // bus reads zero when nothing is enabled
                srcReg   = 3'd1,  // one of the general registers
                srcPc    = 3'd2,
                srcZHigh = 3'd3,
                srcZLow  = 3'd4,
                srcMdr   = 3'd5,
                srcIr    = 3'd6
        } busSource;

        // ALU operation codes as driven on aluCode
        typedef enum logic [4:0] {
                opAdd   = 5'd0,   // Y + bus
                opSub   = 5'd1,   // Y - bus
                opAnd   = 5'd2,
                opOr    = 5'd3,
                opShl   = 5'd4,   // Y << bus[4:0]
                opShr   = 5'd5,   // logical Y >> bus[4:0]
                opNeg   = 5'd6,   // two's complement of the bus
                opNot   = 5'd7,   // bitwise inverse of the bus
                opMul   = 5'd8,   // signed, full 64-bit product
                opIncPc = 5'd9,   // bus + 1 with Y ignored
                opPass  = 5'd10   // bus copied to the low half
        } aluOp;

endpackage

// File: src/memDataReg.sv
module memDataReg (
        input  logic                         Clock,
        input  logic                         rstN,
        input  logic [cpuPkg::dataWidth-1:0] busData,
        input  logic [cpuPkg::dataWidth-1:0] mdataIn,
        input  logic                         read,
        input  logic                         mdrIn,
        output logic [cpuPkg::dataWidth-1:0] mdrValue
);

        logic [cpuPkg::dataWidth-1:0] nextValue;

        // memory read data wins over the bus while read is high
        assign nextValue = read ? mdataIn : busData;

        always_ff @(posedge Clock) begin
                if (!rstN)
                        mdrValue <= '0;
                else if (mdrIn)
                        mdrValue <= nextValue;
        end

endmodule

// File: src/registerFile.sv
module registerFile (
        input  logic                         Clock,
        input  logic                         rstN,
        input  logic [cpuPkg::dataWidth-1:0] busData,
        input  logic [cpuPkg::regCount-1:0]  regIn,
        input  logic [cpuPkg::regCount-1:0]  regOut,
        output logic [cpuPkg::dataWidth-1:0] regValue
);

        logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

        // every register with its regIn bit set takes the bus at the edge
        always_ff @(posedge Clock) begin
                for (int i = 0; i < cpuPkg::regCount; i++) begin
                        if (!rstN)
                                regs[i] <= '0;
                        else if (regIn[i])
                                regs[i] <= busData;
                end
        end

        // read port as an and-or mux since regOut is one-hot or zero
        always_comb begin
                regValue = '0;
                for (int i = 0; i < cpuPkg::regCount; i++) begin
                        if (regOut[i])
                                regValue = regValue | regs[i];
                end
        end

        // the sequencer may enable at most one register onto the bus per step
        assert property (@(posedge Clock) disable iff (!rstN) $onehot0(regOut))
                else $error("registerFile: more than one regOut bit high (%b)", regOut);

        // a register loaded in one step reads back the same word when enabled next step
        assert property (@(posedge Clock) disable iff (!rstN)
                        $past(regIn) != '0 && regOut == $past(regIn) |->
                        regValue == $past(busData))
                else $error("registerFile: read back differs from loaded word");

endmodule

// File: include/datapathTasks.svh
`ifndef DATAPATH_TASKS_SVH
`define DATAPATH_TASKS_SVH

function automatic void reportError(input string msg);
        errorCount++;
        $display("ERROR at %0t: %s", $time, msg);
endfunction

// expected Z for one ALU step with Y on the left and the bus on the right
function automatic logic [2*cpuPkg::dataWidth-1:0] aluModel(input cpuPkg::aluOp op,
                input logic [cpuPkg::dataWidth-1:0] y, input logic [cpuPkg::dataWidth-1:0] b);
        logic [cpuPkg::dataWidth-1:0]   low;
        logic [2*cpuPkg::dataWidth-1:0] yWide;
        logic [2*cpuPkg::dataWidth-1:0] bWide;
        yWide = {{cpuPkg::dataWidth{y[cpuPkg::dataWidth-1]}}, y};  // sign extended
        bWide = {{cpuPkg::dataWidth{b[cpuPkg::dataWidth-1]}}, b};
        case (op)
                cpuPkg::opAdd:   low = y + b;
                cpuPkg::opSub:   low = y - b;
                cpuPkg::opAnd:   low = y & b;
                cpuPkg::opOr:    low = y | b;
                cpuPkg::opShl:   low = y << b[4:0];
                cpuPkg::opShr:   low = y >> b[4:0];
                cpuPkg::opNeg:   low = '0 - b;
                cpuPkg::opNot:   low = ~b;
                cpuPkg::opIncPc: low = b + 1;
                cpuPkg::opPass:  low = b;
                default:         low = '0;
        endcase
        if (op == cpuPkg::opMul)
                return yWide * bWide;  // full signed product
        return {{cpuPkg::dataWidth{1'b0}}, low};
endfunction

task automatic clearStrobes();
        {pcOut, zHighOut, zLowOut, mdrOut, irOut, pcIn, irIn, yIn} = '0;
        {marIn, zIn, mdrIn, incPc, read, busValid} = '0;
        regOut = '0;
        regIn = '0;
        aluCode = cpuPkg::opPass;  // any defined code while zIn is low
endtask

// one control step with its strobes set 1 unit after the last edge
task automatic runStep(input logic [cpuPkg::dataWidth-1:0] busWord);
        busExpect = busWord;
        busValid = 1'b1;
        @(posedge Clock);
        #1;
        if (mdrIn)
                mdrModel = read ? mdataIn : busWord;
        if (marIn)
                marModel = busWord;
        if (irIn)
                irModel = busWord;
        clearStrobes();
endtask

task automatic waitForWord(input string what, input logic [cpuPkg::dataWidth-1:0] value,
                           input int limit);
        logic [cpuPkg::dataWidth-1:0] seen;
        int cycles;
        cycles = 0;
        seen = what == "MDR" ? mdrValue : (what == "MAR" ? marValue : irValue);
        while (seen !== value && cycles < limit) begin
                @(posedge Clock);
                #1;
                cycles++;
                seen = what == "MDR" ? mdrValue : (what == "MAR" ? marValue : irValue);
        end
        assert (seen === value) else begin
                errorCount++;
                $display("timeout: %s never held %h within %0d cycles", what, value, limit);
        end
endtask

// memory read with no wait states while the bus stays idle
task automatic readMemory(input logic [cpuPkg::dataWidth-1:0] value);
        mdataIn = value;
        read = 1'b1;
        mdrIn = 1'b1;
        runStep('0);
        waitForWord("MDR", value, 4);
endtask

task automatic loadRegister(input int index, input logic [cpuPkg::dataWidth-1:0] value);
        readMemory(value);
        mdrOut = 1'b1;
        regIn[index] = 1'b1;
        runStep(value);
endtask

task automatic endTest(input string name);
        testsRun++;
        if (errorCount == errorsAtStart) begin
                $display("test %s: passed", name);
        end else begin
                testsFailed++;
                $display("test %s: failed, %0d errors", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
endtask

`endif

// File: verification/datapathTb.sv
module datapathTb;

        logic                           Clock;
        logic                           rstN;
        logic                           pcOut, zHighOut, zLowOut, mdrOut, irOut;
        logic                           pcIn, irIn, yIn, marIn, zIn, mdrIn;
        logic                           incPc;
        logic                           read;
        logic [cpuPkg::regCount-1:0]    regOut;
        logic [cpuPkg::regCount-1:0]    regIn;
        cpuPkg::aluOp                   aluCode;
        logic [cpuPkg::dataWidth-1:0]   mdataIn;
        logic [cpuPkg::dataWidth-1:0]   busData, mdrValue, marValue, irValue;
        logic [cpuPkg::dataWidth-1:0]   busExpect, mdrModel, marModel, irModel;
        logic                           busValid;  // bus is checked in this step
        logic [cpuPkg::dataWidth-1:0]   word, opA, opB;
        logic [2*cpuPkg::dataWidth-1:0] aluWant;
        cpuPkg::aluOp                   op;
        integer                         seed;
        int                             errorCount, errorsAtStart, testsRun, testsFailed;

        `include "datapathTasks.svh"

        cpuDatapath i_cpuDatapath (.*);

        initial begin
                Clock = 1'b0;
                forever #4 Clock = ~Clock;
        end

        assert property (@(posedge Clock) disable iff (!rstN)
                        busValid |-> busData == busExpect)
                else reportError($sformatf("busData differs from model, expected %h", busExpect));

        // MDR, MAR and IR follow their load strobes
        assert property (@(posedge Clock) disable iff (!rstN)
                        {mdrValue, marValue, irValue} == {mdrModel, marModel, irModel})
                else reportError($sformatf("MDR/MAR/IR differ from model %h %h %h",
                                           mdrModel, marModel, irModel));

        initial begin
                seed = 32'hf8c6380c;
                errorCount = 0;
                errorsAtStart = 0;
                testsRun = 0;
                testsFailed = 0;
                {busExpect, mdrModel, marModel, irModel} = '0;
                mdataIn = '0;
                rstN = 1'b0;
                clearStrobes();
                repeat (8) @(posedge Clock);
                #1;
                rstN = 1'b1;

                assert (busData === '0 && mdrValue === '0 && marValue === '0 && irValue === '0)
                        else reportError("outputs not zero after reset");
                endTest("reset");

                word = $random(seed);
                loadRegister(4, word);  // memory word into R4 through the MDR
                regOut[4] = 1'b1;
                runStep(word);
                endTest("memory to R4");

                // Y from R1, the operation on R2, then both halves of Z
                op = op.first();
                repeat (op.num()) begin
                        if (op != cpuPkg::opIncPc) begin
                                opA = $random(seed);
                                opB = $random(seed);
                                aluWant = aluModel(op, opA, opB);
                                loadRegister(1, opA);
                                loadRegister(2, opB);
                                regOut[1] = 1'b1;
                                yIn = 1'b1;
                                runStep(opA);
                                regOut[2] = 1'b1;
                                aluCode = op;
                                zIn = 1'b1;
                                runStep(opB);
                                zLowOut = 1'b1;
                                runStep(aluWant[cpuPkg::dataWidth-1:0]);
                                zHighOut = 1'b1;  // zero unless multiply
                                runStep(aluWant[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth]);
                                endTest($sformatf("alu %s", op.name()));
                        end
                        op = op.next();
                end

                word = $random(seed);
                readMemory(word);
                mdrOut = 1'b1;
                pcIn = 1'b1;  // start PC at a random address
                runStep(word);
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;
                zIn = 1'b1;
                runStep(word);
                zLowOut = 1'b1;
                pcIn = 1'b1;
                runStep(word + 1);
                waitForWord("MAR", word, 4);
                pcOut = 1'b1;
                runStep(word + 1);
                endTest("fetch");

                word = $random(seed);
                readMemory(word);
                mdrOut = 1'b1;
                irIn = 1'b1;
                runStep(word);
                waitForWord("IR", word, 4);
                endTest("instruction load");

                runStep('0);  // no out-enable high
                endTest("idle bus");

                $display("tests run: %0d, failed: %0d, errors: %0d",
                         testsRun, testsFailed, errorCount);
                if (errorCount == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule
